// File: common/jvm_pkg.sv
package jvm_pkg;

    typedef logic [31:0] word_t;    // one eval stack / lva / data-segment word
    typedef logic [15:0] addr_t;    // code, data and lva addresses

    // bytecode values, jvm numbering
    typedef enum logic [7:0] {
        ICONST_M1    = 8'h02,
        ICONST_0     = 8'h03,
        ICONST_1     = 8'h04,
        ICONST_2     = 8'h05,
        ICONST_3     = 8'h06,
        ICONST_4     = 8'h07,
        ICONST_5     = 8'h08,
        BIPUSH       = 8'h10,    // arg1 is a signed byte
        LDC          = 8'h12,    // arg1 indexes the data segment
        ILOAD        = 8'h15,
        ISTORE       = 8'h36,
        IADD         = 8'h60,
        ISUB         = 8'h64,
        GOTO         = 8'ha7,    // {arg1, arg2} signed offset from this opcode
        IRETURN      = 8'hac,
        RETURN       = 8'hb1,
        INVOKESTATIC = 8'hb8     // {arg1, arg2} indexes the method descriptor
    } opcode_e;

    // data-segment word, a constant for ldc or a descriptor for invokestatic
    typedef union packed {
        logic signed [31:0] constant;
        struct packed {
            addr_t      code_addr;    // entry point of the callee
            logic [7:0] arg_count;    // words moved from eval stack into the new frame
            logic [7:0] lva_max;      // frame size, arg_count <= lva_max
        } method;
    } data_word_u;

    // one call stack entry
    typedef struct packed {
        addr_t ret_pc;      // pc of the instruction after the invoke
        addr_t lva_base;    // caller frame base
    } frame_t;

    typedef enum logic {
        CALL_INVOKE,
        CALL_RETURN
    } call_kind_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_DESC_WAIT,       // data_index switched, data word not valid yet
        S_DESC_LOAD,
        S_ARG_NEXT,
        S_ARG_POP_WAIT,
        S_ARG_WRITE_WAIT,
        S_CS_PUSH_WAIT,
        S_CS_POP_WAIT
    } invoke_state_e;

endpackage

// File: common/store_if.sv
`timescale 1ns/1ns

// one trigger/done request to a storage block
interface store_if #(
    parameter int ADDR_W = 16,
    parameter int DATA_W = 32
);
    logic              trigger;    // one cycle per request
    logic              write;      // hi write/push, lo read/pop
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;      // valid while done is high
    logic              done;       // one cycle pulse

    modport requester (
        output trigger, write, addr, wdata,
        input  rdata, done
    );

    modport server (
        input  trigger, write, addr, wdata,
        output rdata, done
    );

endinterface

// File: hw/lifo_stack.sv
`timescale 1ns/1ns

module lifo_stack #(
    parameter int DEPTH = 32,
    parameter int WIDTH = 32
) (
    input  logic     clk,
    input  logic     rst,
    store_if.server  port,
    output logic     overflow,     // push while full, push dropped
    output logic     underflow     // pop while empty, pop dropped
);

    localparam int AW = $clog2(DEPTH);
    localparam int PW = $clog2(DEPTH + 1);    // sp can reach DEPTH

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    sp;        // number of entries, next free slot
    logic [PW-1:0]    sp_dec;    // slot of the current top
    logic             full;
    logic             empty;

    assign sp_dec    = sp - 1'b1;
    assign full      = (sp == PW'(DEPTH));
    assign empty     = (sp == '0);
    assign overflow  = port.trigger && port.write && full;
    assign underflow = port.trigger && !port.write && empty;

    // storage and read data
    always_ff @(posedge clk) begin
        if (port.trigger && port.write && !full) begin
            mem[sp[AW-1:0]] <= port.wdata;
        end
        if (port.trigger && !port.write && !empty) begin
            port.rdata <= mem[sp_dec[AW-1:0]];    // pop hands back the old top
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sp        <= '0;
            port.done <= 1'b0;
        end else begin
            port.done <= port.trigger;    // fixed one cycle latency
            if (port.trigger && port.write && !full) begin
                sp <= sp + 1'b1;
            end else if (port.trigger && !port.write && !empty) begin
                sp <= sp_dec;
            end
        end
    end

    a_push_full : assert property (@(posedge clk) disable iff (rst)
        port.trigger && port.write |-> !full)
        else $error("lifo push when full");

    a_pop_empty : assert property (@(posedge clk) disable iff (rst)
        port.trigger && !port.write |-> !empty)
        else $error("lifo pop when empty");

endmodule

// File: hw/local_var_array.sv
`timescale 1ns/1ns

module local_var_array #(
    parameter int SIZE = 256
) (
    input  logic    clk,
    input  logic    rst,
    store_if.server port
);

    localparam int AW = $clog2(SIZE);

    logic [31:0] mem [SIZE];    // frames of every method still running

    always_ff @(posedge clk) begin
        if (port.trigger) begin
            if (port.write) begin
                mem[port.addr[AW-1:0]] <= port.wdata;
            end
            port.rdata <= mem[port.addr[AW-1:0]];    // old value on a write, nobody reads it
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port.done <= 1'b0;
        end else begin
            port.done <= port.trigger;
        end
    end

    // frame base + index must not run past the array
    a_addr_range : assert property (@(posedge clk) disable iff (rst)
        port.trigger |-> port.addr < SIZE)
        else $error("lva address %0d out of range", port.addr);

endmodule

// File: core/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          op_code,
    input  logic [7:0]          arg1,
    input  logic [7:0]          arg2,
    input  jvm_pkg::data_word_u data_word,
    output jvm_pkg::addr_t      data_index,
    output jvm_pkg::addr_t      pc,
    input  jvm_pkg::addr_t      frame_base,
    store_if.requester          eval,
    store_if.requester          lva,
    output logic                call_req,     // single cycle handover to invoke_fsm
    output jvm_pkg::call_kind_e call_kind,
    output jvm_pkg::addr_t      desc_index,
    input  logic                call_done,
    input  jvm_pkg::addr_t      new_pc,
    input  jvm_pkg::addr_t      new_base,
    input  logic                call_depth_zero,
    output logic                halted,
    output jvm_pkg::word_t      result
);

    typedef enum logic [3:0] {
        X_FETCH, X_LDC, X_LOAD_WAIT, X_STORE_POP, X_STORE_WAIT, X_POP_B,
        X_POP_A, X_PUSH_WAIT, X_CALL, X_RET_POP, X_HALT
    } exec_state_e;

    exec_state_e    state;
    jvm_pkg::word_t operand_b;    // first pop of iadd/isub is the right-hand side
    logic           op_done;      // last cycle of the current instruction
    jvm_pkg::addr_t op_len;

    assign data_index = {8'h00, arg1};    // ldc index with the data word valid a cycle later
    assign desc_index = {arg1, arg2};
    assign eval.addr  = '0;

    always_comb begin
        case (op_code)
            jvm_pkg::BIPUSH, jvm_pkg::LDC, jvm_pkg::ILOAD, jvm_pkg::ISTORE: op_len = 16'd2;
            default: op_len = 16'd1;
        endcase
        op_done = (state == X_PUSH_WAIT && eval.done) ||
                  (state == X_STORE_WAIT && lva.done) ||
                  (state == X_CALL && call_done) ||
                  (state == X_FETCH && op_code == jvm_pkg::GOTO);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= X_FETCH;
            pc           <= '0;
            eval.trigger <= 1'b0;
            lva.trigger  <= 1'b0;
            call_req     <= 1'b0;
            halted       <= 1'b0;
        end else begin
            eval.trigger <= 1'b0;    // all requests are single pulses
            lva.trigger  <= 1'b0;
            call_req     <= 1'b0;
            if (op_done) begin
                if (state == X_CALL) begin
                    pc <= new_pc;
                end else if (op_code == jvm_pkg::GOTO) begin
                    pc <= pc + {arg1, arg2};    // 16 bit wrap gives the signed add
                end else begin
                    pc <= pc + op_len;
                end
            end
            case (state)
                X_FETCH: begin
                    case (op_code)
                        jvm_pkg::ICONST_M1, jvm_pkg::ICONST_0, jvm_pkg::ICONST_1,
                        jvm_pkg::ICONST_2, jvm_pkg::ICONST_3, jvm_pkg::ICONST_4,
                        jvm_pkg::ICONST_5: begin
                            eval.write   <= 1'b1;
                            eval.wdata   <= {24'h0, op_code} - 32'd3;    // iconst_0 is 0x03
                            eval.trigger <= 1'b1;
                            state        <= X_PUSH_WAIT;
                        end
                        jvm_pkg::BIPUSH: begin
                            eval.write   <= 1'b1;
                            eval.wdata   <= {{24{arg1[7]}}, arg1};
                            eval.trigger <= 1'b1;
                            state        <= X_PUSH_WAIT;
                        end
                        jvm_pkg::LDC: state <= X_LDC;
                        jvm_pkg::ILOAD: begin
                            lva.write   <= 1'b0;
                            lva.addr    <= frame_base + {8'h00, arg1};
                            lva.trigger <= 1'b1;
                            state       <= X_LOAD_WAIT;
                        end
                        jvm_pkg::ISTORE, jvm_pkg::IADD, jvm_pkg::ISUB: begin
                            eval.write   <= 1'b0;
                            eval.trigger <= 1'b1;
                            state        <= (op_code == jvm_pkg::ISTORE) ? X_STORE_POP : X_POP_B;
                        end
                        jvm_pkg::INVOKESTATIC: begin
                            call_req  <= 1'b1;
                            call_kind <= jvm_pkg::CALL_INVOKE;
                            state     <= X_CALL;
                        end
                        jvm_pkg::IRETURN, jvm_pkg::RETURN: begin
                            if (!call_depth_zero) begin
                                call_req  <= 1'b1;    // ireturn value stays on the eval stack
                                call_kind <= jvm_pkg::CALL_RETURN;
                                state     <= X_CALL;
                            end else if (op_code == jvm_pkg::IRETURN) begin
                                eval.write   <= 1'b0;    // outermost ireturn pops the result
                                eval.trigger <= 1'b1;
                                state        <= X_RET_POP;
                            end else begin
                                halted <= 1'b1;
                                state  <= X_HALT;
                            end
                        end
                        default: ;    // goto finishes here through op_done
                    endcase
                end
                X_LDC: begin
                    eval.write   <= 1'b1;
                    eval.wdata   <= data_word.constant;
                    eval.trigger <= 1'b1;
                    state        <= X_PUSH_WAIT;
                end
                X_LOAD_WAIT: begin
                    if (lva.done) begin
                        eval.write   <= 1'b1;
                        eval.wdata   <= lva.rdata;
                        eval.trigger <= 1'b1;
                        state        <= X_PUSH_WAIT;
                    end
                end
                X_STORE_POP: begin
                    if (eval.done) begin
                        lva.write   <= 1'b1;
                        lva.addr    <= frame_base + {8'h00, arg1};
                        lva.wdata   <= eval.rdata;
                        lva.trigger <= 1'b1;
                        state       <= X_STORE_WAIT;
                    end
                end
                X_POP_B: begin
                    if (eval.done) begin
                        operand_b    <= eval.rdata;
                        eval.trigger <= 1'b1;    // second pop with write still low
                        state        <= X_POP_A;
                    end
                end
                X_POP_A: begin
                    if (eval.done) begin
                        eval.write   <= 1'b1;
                        eval.wdata   <= (op_code == jvm_pkg::IADD) ? eval.rdata + operand_b
                                                                   : eval.rdata - operand_b;
                        eval.trigger <= 1'b1;
                        state        <= X_PUSH_WAIT;
                    end
                end
                X_PUSH_WAIT, X_STORE_WAIT, X_CALL: begin
                    if (op_done) begin
                        state <= X_FETCH;
                    end
                end
                X_RET_POP: begin
                    if (eval.done) begin
                        result <= eval.rdata;
                        halted <= 1'b1;
                        state  <= X_HALT;
                    end
                end
                default: ;    // halted until reset
            endcase
        end
    end

    a_opcode_known : assert property (@(posedge clk) disable iff (rst)
        state == X_FETCH |-> op_code inside {[jvm_pkg::ICONST_M1 : jvm_pkg::ICONST_5],
            jvm_pkg::BIPUSH, jvm_pkg::LDC, jvm_pkg::ILOAD, jvm_pkg::ISTORE, jvm_pkg::IADD,
            jvm_pkg::ISUB, jvm_pkg::GOTO, jvm_pkg::IRETURN, jvm_pkg::RETURN,
            jvm_pkg::INVOKESTATIC})
        else $error("unsupported opcode %02h at pc %0d", op_code, pc);

endmodule

// File: core/invoke_fsm.sv
`timescale 1ns/1ns

module invoke_fsm #(
    parameter int CALL_DEPTH = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                call_req,
    input  jvm_pkg::call_kind_e call_kind,
    input  jvm_pkg::addr_t      desc_index,
    input  jvm_pkg::addr_t      pc,
    input  jvm_pkg::data_word_u data_word,
    output jvm_pkg::addr_t      desc_data_index,
    store_if.requester          eval,
    store_if.requester          lva,
    store_if.requester          callstk,
    output logic                fsm_owns,          // eval and lva muxed to this fsm
    output logic                call_done,
    output jvm_pkg::addr_t      new_pc,
    output jvm_pkg::addr_t      new_base,
    output jvm_pkg::addr_t      frame_base,
    output logic                call_depth_zero
);

    localparam int DW = $clog2(CALL_DEPTH + 1);

    jvm_pkg::invoke_state_e state;
    logic [DW-1:0]          depth;          // frames on the call stack
    jvm_pkg::addr_t         code_addr;
    jvm_pkg::addr_t         callee_base;
    logic [7:0]             arg_cnt;        // args still to move, counts down
    jvm_pkg::frame_t        popped;

    assign popped          = callstk.rdata;
    assign call_depth_zero = (depth == '0);

    // eval is only popped and lva only written from here
    assign eval.write   = 1'b0;
    assign eval.addr    = '0;
    assign eval.wdata   = '0;
    assign lva.write    = 1'b1;
    assign callstk.addr = '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= jvm_pkg::S_IDLE;
            depth           <= '0;
            frame_base      <= '0;
            fsm_owns        <= 1'b0;
            call_done       <= 1'b0;
            eval.trigger    <= 1'b0;
            lva.trigger     <= 1'b0;
            callstk.trigger <= 1'b0;
        end else begin
            call_done       <= 1'b0;
            eval.trigger    <= 1'b0;
            lva.trigger     <= 1'b0;
            callstk.trigger <= 1'b0;
            case (state)
                jvm_pkg::S_IDLE: begin
                    if (call_req) begin
                        fsm_owns <= 1'b1;
                        if (call_kind == jvm_pkg::CALL_RETURN) begin
                            callstk.write   <= 1'b0;
                            callstk.trigger <= 1'b1;
                            state           <= jvm_pkg::S_CS_POP_WAIT;
                        end else begin
                            desc_data_index <= desc_index;
                            state           <= jvm_pkg::S_DESC_WAIT;
                        end
                    end
                end
                jvm_pkg::S_DESC_WAIT: state <= jvm_pkg::S_DESC_LOAD;
                jvm_pkg::S_DESC_LOAD: begin
                    code_addr   <= data_word.method.code_addr;
                    arg_cnt     <= data_word.method.arg_count;
                    callee_base <= frame_base + {8'h00, data_word.method.lva_max};
                    state       <= jvm_pkg::S_ARG_NEXT;
                end
                jvm_pkg::S_ARG_NEXT: begin
                    if (arg_cnt != 8'd0) begin
                        eval.trigger <= 1'b1;
                        state        <= jvm_pkg::S_ARG_POP_WAIT;
                    end else begin
                        callstk.write   <= 1'b1;
                        callstk.wdata   <= jvm_pkg::frame_t'{ret_pc: pc + 16'd3,
                                                             lva_base: frame_base};
                        callstk.trigger <= 1'b1;
                        state           <= jvm_pkg::S_CS_PUSH_WAIT;
                    end
                end
                jvm_pkg::S_ARG_POP_WAIT: begin
                    if (eval.done) begin
                        // top of stack is the last argument, highest index
                        lva.addr    <= callee_base + {8'h00, arg_cnt} - 16'd1;
                        lva.wdata   <= eval.rdata;
                        lva.trigger <= 1'b1;
                        state       <= jvm_pkg::S_ARG_WRITE_WAIT;
                    end
                end
                jvm_pkg::S_ARG_WRITE_WAIT: begin
                    if (lva.done) begin
                        arg_cnt <= arg_cnt - 8'd1;
                        state   <= jvm_pkg::S_ARG_NEXT;
                    end
                end
                jvm_pkg::S_CS_PUSH_WAIT: begin
                    if (callstk.done) begin
                        new_pc     <= code_addr;
                        new_base   <= callee_base;
                        frame_base <= callee_base;
                        depth      <= depth + 1'b1;
                        call_done  <= 1'b1;
                        fsm_owns   <= 1'b0;
                        state      <= jvm_pkg::S_IDLE;
                    end
                end
                jvm_pkg::S_CS_POP_WAIT: begin
                    if (callstk.done) begin
                        new_pc     <= popped.ret_pc;
                        new_base   <= popped.lva_base;
                        frame_base <= popped.lva_base;
                        depth      <= depth - 1'b1;
                        call_done  <= 1'b1;
                        fsm_owns   <= 1'b0;
                        state      <= jvm_pkg::S_IDLE;
                    end
                end
                default: state <= jvm_pkg::S_IDLE;
            endcase
        end
    end

    // exec unit waits for call_done before it can ask again
    a_req_idle : assert property (@(posedge clk) disable iff (rst)
        call_req |-> state == jvm_pkg::S_IDLE)
        else $error("call_req while invoke fsm busy");

endmodule

// File: hw/stack_cpu_top.sv
`timescale 1ns/1ns

module stack_cpu_top #(
    parameter int EVAL_DEPTH = 32,
    parameter int CALL_DEPTH = 16,
    parameter int LVA_SIZE   = 256
) (
    input  logic           clk,
    input  logic           rst,
    input  logic [7:0]     op_code,
    input  logic [7:0]     arg1,
    input  logic [7:0]     arg2,
    input  jvm_pkg::word_t data_word,
    output jvm_pkg::addr_t program_counter,
    output jvm_pkg::addr_t data_index,
    output logic           halted,
    output jvm_pkg::word_t result
);

    store_if eval_exec ();
    store_if eval_fsm ();
    store_if eval_bus ();
    store_if lva_exec ();
    store_if lva_fsm ();
    store_if lva_bus ();
    store_if call_bus ();    // invoke_fsm only

    jvm_pkg::data_word_u data_u;
    jvm_pkg::addr_t      pc;
    jvm_pkg::addr_t      exec_data_index;
    jvm_pkg::addr_t      desc_data_index;
    jvm_pkg::addr_t      desc_index;
    jvm_pkg::addr_t      frame_base;
    jvm_pkg::addr_t      new_pc;
    jvm_pkg::addr_t      new_base;
    jvm_pkg::call_kind_e call_kind;
    logic                fsm_owns;
    logic                call_req;
    logic                call_done;
    logic                call_depth_zero;

    assign data_u          = data_word;
    assign program_counter = pc;
    assign data_index      = fsm_owns ? desc_data_index : exec_data_index;

    // eval stack ownership, only the owner issues triggers
    assign eval_bus.trigger = fsm_owns ? eval_fsm.trigger : eval_exec.trigger;
    assign eval_bus.write   = fsm_owns ? eval_fsm.write   : eval_exec.write;
    assign eval_bus.addr    = fsm_owns ? eval_fsm.addr    : eval_exec.addr;
    assign eval_bus.wdata   = fsm_owns ? eval_fsm.wdata   : eval_exec.wdata;
    assign eval_exec.rdata  = eval_bus.rdata;
    assign eval_exec.done   = eval_bus.done;
    assign eval_fsm.rdata   = eval_bus.rdata;
    assign eval_fsm.done    = eval_bus.done;

    // lva ownership, same rule
    assign lva_bus.trigger = fsm_owns ? lva_fsm.trigger : lva_exec.trigger;
    assign lva_bus.write   = fsm_owns ? lva_fsm.write   : lva_exec.write;
    assign lva_bus.addr    = fsm_owns ? lva_fsm.addr    : lva_exec.addr;
    assign lva_bus.wdata   = fsm_owns ? lva_fsm.wdata   : lva_exec.wdata;
    assign lva_exec.rdata  = lva_bus.rdata;
    assign lva_exec.done   = lva_bus.done;
    assign lva_fsm.rdata   = lva_bus.rdata;
    assign lva_fsm.done    = lva_bus.done;

    exec_unit exec0 (
        .clk(clk), .rst(rst),
        .op_code(op_code), .arg1(arg1), .arg2(arg2),
        .data_word(data_u), .data_index(exec_data_index),
        .pc(pc), .frame_base(frame_base),
        .eval(eval_exec.requester), .lva(lva_exec.requester),
        .call_req(call_req), .call_kind(call_kind), .desc_index(desc_index),
        .call_done(call_done), .new_pc(new_pc), .new_base(new_base),
        .call_depth_zero(call_depth_zero),
        .halted(halted), .result(result)
    );

    invoke_fsm #(.CALL_DEPTH(CALL_DEPTH)) invoke0 (
        .clk(clk), .rst(rst),
        .call_req(call_req), .call_kind(call_kind), .desc_index(desc_index),
        .pc(pc), .data_word(data_u), .desc_data_index(desc_data_index),
        .eval(eval_fsm.requester), .lva(lva_fsm.requester),
        .callstk(call_bus.requester), .fsm_owns(fsm_owns),
        .call_done(call_done), .new_pc(new_pc), .new_base(new_base),
        .frame_base(frame_base), .call_depth_zero(call_depth_zero)
    );

    lifo_stack #(.DEPTH(EVAL_DEPTH), .WIDTH(32)) eval_stack (
        .clk(clk), .rst(rst), .port(eval_bus.server), .overflow(), .underflow()
    );

    lifo_stack #(.DEPTH(CALL_DEPTH), .WIDTH(32)) call_stack (
        .clk(clk), .rst(rst), .port(call_bus.server), .overflow(), .underflow()
    );

    local_var_array #(.SIZE(LVA_SIZE)) lva0 (
        .clk(clk), .rst(rst), .port(lva_bus.server)
    );

endmodule

// File: tests/tb_stack_cpu.sv
`timescale 1ns/1ns

module tb_stack_cpu;

    localparam int NUM_TESTS    = 5;
    localparam int BLOCK        = 64;     // words per test section in the input file
    localparam int DATA_OFS     = 4;      // data-segment words start here in a section
    localparam int MAX_DATA     = 4;
    localparam int CODE_OFS     = 8;      // code bytes, one per word
    localparam int CYC_PER_BYTE = 200;

    logic           clk;
    logic           rst       = 1'b1;
    logic [7:0]     op_code   = 8'h00;
    logic [7:0]     arg1      = 8'h00;
    logic [7:0]     arg2      = 8'h00;
    jvm_pkg::word_t data_word = '0;
    jvm_pkg::addr_t program_counter;
    jvm_pkg::addr_t data_index;
    logic           halted;
    jvm_pkg::word_t result;

    logic [31:0] image [NUM_TESTS*BLOCK];    // raw sections from the input file
    int          cur          = 0;           // section the memories serve
    int          limit_cycles = 0;
    logic        loaded       = 1'b0;
    string       names [NUM_TESTS];

    stack_cpu_top #(
        .EVAL_DEPTH(32),
        .CALL_DEPTH(16),
        .LVA_SIZE(256)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .op_code(op_code),
        .arg1(arg1),
        .arg2(arg2),
        .data_word(data_word),
        .program_counter(program_counter),
        .data_index(data_index),
        .halted(halted),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // code memory, bytes past the program read as zero
    function automatic logic [7:0] code_byte(input int t, input jvm_pkg::addr_t a);
        if (int'(a) >= int'(image[t*BLOCK])) return 8'h00;
        return image[t*BLOCK + CODE_OFS + int'(a)][7:0];
    endfunction

    // data-segment rom of section t
    function automatic jvm_pkg::word_t data_seg(input int t, input jvm_pkg::addr_t i);
        if (int'(i) >= int'(image[t*BLOCK + 3])) return '0;
        return image[t*BLOCK + DATA_OFS + int'(i)];
    endfunction

    // both roms answer on the falling edge
    always @(negedge clk) begin
        if (loaded) begin
            op_code   <= code_byte(cur, program_counter);
            arg1      <= code_byte(cur, program_counter + 16'd1);
            arg2      <= code_byte(cur, program_counter + 16'd2);
            data_word <= data_seg(cur, data_index);    // old data_index, one cycle behind
        end
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input jvm_pkg::word_t exp,
                              input jvm_pkg::word_t act);
        if (act !== exp) begin
            fail_stop($sformatf("MISMATCH %s result: expected %08h actual %08h",
                                name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input jvm_pkg::addr_t exp,
                              input jvm_pkg::addr_t act);
        if (act !== exp) begin
            fail_stop($sformatf("MISMATCH %s halt pc: expected %04h actual %04h",
                                name, exp, act));
        end
    endtask

    // one section: reset, run to halted, check result and halt address
    task automatic run_test(input int t);
        jvm_pkg::word_t exp_result;
        jvm_pkg::addr_t exp_pc;
        exp_result = image[t*BLOCK + 1];
        exp_pc     = image[t*BLOCK + 2][15:0];
        @(negedge clk);
        rst <= 1'b1;
        cur <= t;    // roms switch while the core is held in reset
        repeat (5) @(negedge clk);
        rst <= 1'b0;
        while (halted !== 1'b1) @(negedge clk);
        check_word(names[t], exp_result, result);
        check_addr(names[t], exp_pc, program_counter);
        $display("%s done, result %08h at pc %04h", names[t], result, program_counter);
    endtask

    initial begin
        int max_len;
        max_len = 0;
        names = '{"const_arith", "local_vars", "ldc_const", "invoke_args", "nested_goto"};
        $readmemh("tests/program_input.mem", image);
        for (int t = 0; t < NUM_TESTS; t++) begin
            if ($isunknown(image[t*BLOCK]) || $isunknown(image[t*BLOCK + 3])) begin
                fail_stop($sformatf("section %0d of program_input.mem is missing", t));
            end
            if (image[t*BLOCK] > 32'(BLOCK - CODE_OFS) || image[t*BLOCK + 3] > MAX_DATA) begin
                fail_stop($sformatf("section %0d does not fit its block", t));
            end
            if (int'(image[t*BLOCK]) > max_len) max_len = int'(image[t*BLOCK]);
        end
        limit_cycles = NUM_TESTS * (CYC_PER_BYTE * max_len + 10);    // +10 covers reset
        loaded = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("sim passed");
        $finish;
    end

    // whole run bounded by the longest program
    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge clk);
        fail_stop("watchdog timeout: core never halted");
    end

endmodule

// File: tests/program_input.mem
// each section at a multiple of 0x40 words: code length, expected result, expected halt pc,
// data word count; then four data-segment words; then the code bytes from address 0 on
// const_arith: bipush 3, bipush 100, isub, iconst_2, iadd, ireturn
@000
00000008 ffffffa1 00000007 00000000
00000000 00000000 00000000 00000000
10 03 10 64 64 05 60 ac
// local_vars: 42 to l0, -3 to l1, copy l0 to l2, l2 - l1, ireturn
@040
00000012 0000002d 00000011 00000000
00000000 00000000 00000000 00000000
10 2a 36 00 10 fd 36 01 15 00 36 02 15 02 15 01
64 ac
// ldc_const: ldc 0 stored away, ldc 1 returned as is
@080
00000007 8badf00d 00000006 00000002
12345678 8badf00d 00000000 00000000
12 00 36 00 12 01 ac
// invoke_args: l0 = 77, call sub(50, 8) at 0x10 with 4 locals, add l0, ireturn
@0c0
0000001a 00000077 0000000e 00000001
00100204 00000000 00000000 00000000
10 4d 36 00 10 32 10 08 b8 00 00 15 00 60 ac 00
15 00 15 01 64 36 02 15 02 ac
// nested_goto: main calls a(20) at 0x0c, a calls b(20, 5) at 0x18, goto skips iconst_m1
@100
0000001e 00000023 00000009 00000002
000c0103 00180202 00000000 00000000
10 14 b8 00 00 a7 00 04 02 ac 00 00 15 00 10 05
b8 00 01 15 00 60 ac 00 15 00 15 01 64 ac

// File: files.f
common/jvm_pkg.sv
common/store_if.sv
hw/lifo_stack.sv
hw/local_var_array.sv
core/exec_unit.sv
core/invoke_fsm.sv
hw/stack_cpu_top.sv
tests/tb_stack_cpu.sv

// File: Makefile
# Verilator build and run for the stack machine testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_stack_cpu -f files.f

run: compile
	./obj_dir/Vtb_stack_cpu 2>&1 | tee sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "sim passed" sim.log; then \
		echo "simulation ended without a verdict"; exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir sim.log
